// File: Makefile
# Verilator build and run of the CPU port testbench

SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_cpu_port
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: cpu_port_decode.sv
/*
 * CPU strobe falling-edge detection
 * One pulse per access, selected by MODE
 */
`timescale 1ns/1ps

module cpu_port_decode (
    input  logic                    CLK,
    input  logic                    RESET_n,
    input  logic                    CSR_n,
    input  logic                    CSW_n,
    input  vdp_port_pkg::port_num_t MODE,
    output logic                    vram_wr,
    output logic                    vram_rd,
    output logic                    reg_wr,
    output logic                    reg_rd,
    output logic                    ptr_wr,
    output logic                    status_rd,
    output logic                    int_wr,
    output logic                    int_rd,
    output logic                    sys_wr,
    output logic                    other_rd
);
    import vdp_port_pkg::*;

    logic prev_csr_n;   // Strobe levels on the last edge
    logic prev_csw_n;
    logic rd_edge;
    logic wr_edge;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_csr_n <= 1'b1;
            prev_csw_n <= 1'b1;
        end else begin
            prev_csr_n <= CSR_n;
            prev_csw_n <= CSW_n;
        end
    end

    assign rd_edge = prev_csr_n & ~CSR_n;  // High then low
    assign wr_edge = prev_csw_n & ~CSW_n;

    always_comb begin
        vram_wr   = 1'b0;
        vram_rd   = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        ptr_wr    = 1'b0;
        status_rd = 1'b0;
        int_wr    = 1'b0;
        int_rd    = 1'b0;
        sys_wr    = 1'b0;
        other_rd  = 1'b0;
        case (MODE)
            PORT_VRAM: begin
                vram_wr = wr_edge;
                vram_rd = rd_edge;
            end
            PORT_REG_DATA: begin
                reg_wr = wr_edge;
                reg_rd = rd_edge;
            end
            PORT_REG_SEL: begin
                ptr_wr   = wr_edge;
                other_rd = rd_edge;  // Pointer is write only
            end
            PORT_STATUS:   status_rd = rd_edge;  // Writes ignored
            PORT_INT_FLAG: begin
                int_wr = wr_edge;
                int_rd = rd_edge;
            end
            PORT_SYS_CTRL: begin
                sys_wr   = wr_edge;
                other_rd = rd_edge;
            end
            PORT_PALETTE, PORT_CMD_DATA: other_rd = rd_edge;  // Unserved ports
            default: other_rd = rd_edge;
        endcase
    end

endmodule

// File: cpu_port_top.sv
/*
 * CPU I/O port block of the bitmap VDP
 * Strobe decode, register file, VRAM access, interrupt flags
 * Port 7 system control, port 5 status, CD_OUT and WAIT_n
 */
`timescale 1ns/1ps
`include "vdp_port_defines.svh"

module cpu_port_top (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     CSR_n,
    input  logic                     CSW_n,
    input  vdp_port_pkg::port_num_t  MODE,
    input  vdp_port_pkg::cpu_data_t  CD_IN,
    output vdp_port_pkg::cpu_data_t  CD_OUT,
    output logic                     WAIT_n,
    output logic                     INT0_n,
    output logic                     INT1_n,
    output logic                     vram_we_n,
    output logic                     vram_oe_n,
    output vdp_port_pkg::vram_addr_t vram_addr,
    output vdp_port_pkg::cpu_data_t  vram_din,
    input  vdp_port_pkg::cpu_data_t  vram_dout,
    input  logic                     vram_busy,
    input  logic                     stat_tr,
    input  logic                     stat_vr,
    input  logic                     stat_hr,
    input  logic                     stat_bd,
    input  logic                     stat_eo,
    input  logic                     stat_ce,
    input  logic                     ce_event,
    input  logic                     hi_event,
    input  logic                     vi_event,
    output logic                     srs,
    output logic                     mcs,
    output logic                     cmd_start,
    output vdp_port_pkg::cmd_op_t    cmd_op
);
    import vdp_port_pkg::*;

    logic       vram_wr, vram_rd, reg_wr, reg_rd, ptr_wr;
    logic       status_rd, int_wr, int_rd, sys_wr, other_rd;
    logic       vram_wr_go, vram_rd_go;     // Port 0 strobes when idle
    logic       vram_done;
    logic       vram_rd_pend;               // Access in flight is a read
    logic [2:0] int_enable;
    cpu_data_t  reg_rdata, int_rdata, vram_rdata, status_byte;
    vram_addr_t vram_waddr, vram_raddr;

    cpu_port_decode u_decode (
        .CLK, .RESET_n, .CSR_n, .CSW_n, .MODE,
        .vram_wr, .vram_rd, .reg_wr, .reg_rd, .ptr_wr,
        .status_rd, .int_wr, .int_rd, .sys_wr, .other_rd
    );

    // WAIT_n high only when no access runs, so overlaps drop out here
    assign vram_wr_go = vram_wr && WAIT_n;
    assign vram_rd_go = vram_rd && WAIT_n;

    vdp_register_file u_regs (
        .CLK, .RESET_n, .reg_wr, .reg_rd, .ptr_wr,
        .vram_wr(vram_wr_go), .vram_rd(vram_rd_go), .CD_IN,
        .reg_rdata, .vram_waddr, .vram_raddr, .int_enable, .cmd_start, .cmd_op
    );

    vram_access u_vram (
        .CLK, .RESET_n, .vram_wr(vram_wr_go), .vram_rd(vram_rd_go),
        .vram_waddr, .vram_raddr, .CD_IN,
        .vram_we_n, .vram_oe_n, .vram_addr, .vram_din, .vram_dout, .vram_busy,
        .vram_done, .vram_rdata
    );

    interrupt_flags u_int (
        .CLK, .RESET_n, .int_wr, .CD_IN, .ce_event, .hi_event, .vi_event,
        .int_enable, .int_rdata, .INT0_n, .INT1_n
    );

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            srs <= 1'b0;
            mcs <= 1'b0;
        end else if (sys_wr) begin
            srs <= CD_IN[1];
            mcs <= CD_IN[0];
        end
    end

    // Port 5, bit 3 reads zero
    assign status_byte = {stat_tr, stat_vr, stat_hr, stat_bd, 1'b0, mcs, stat_eo, stat_ce};

    // Port 0 wait, released the edge after done
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            WAIT_n       <= 1'b1;
            vram_rd_pend <= 1'b0;
        end else if (vram_done) begin
            WAIT_n       <= 1'b1;
            vram_rd_pend <= 1'b0;
        end else if (vram_wr_go || vram_rd_go) begin
            WAIT_n       <= 1'b0;
            vram_rd_pend <= vram_rd_go;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            CD_OUT <= `CD_IDLE;
        end else if (vram_done && vram_rd_pend) begin
            CD_OUT <= vram_rdata;           // Same edge as WAIT_n rise
        end else if (reg_rd) begin
            CD_OUT <= reg_rdata;
        end else if (status_rd) begin
            CD_OUT <= status_byte;
        end else if (int_rd) begin
            CD_OUT <= int_rdata;
        end else if (other_rd) begin
            CD_OUT <= `CD_IDLE;
        end
    end

endmodule

// File: interrupt_flags.sv
/*
 * Sticky CE, HI and VI interrupt flags
 * Port 6 write-one-to-clear and read value
 * INT0_n / INT1_n from flags and enables
 */
`timescale 1ns/1ps
`include "vdp_port_defines.svh"

module interrupt_flags (
    input  logic                    CLK,
    input  logic                    RESET_n,
    input  logic                    int_wr,
    input  vdp_port_pkg::cpu_data_t CD_IN,
    input  logic                    ce_event,
    input  logic                    hi_event,
    input  logic                    vi_event,
    input  logic [2:0]              int_enable,
    output vdp_port_pkg::cpu_data_t int_rdata,
    output logic                    INT0_n,
    output logic                    INT1_n
);

    logic [2:0] flags;      // CE, HI, VI
    logic [2:0] events;
    logic [2:0] clr;

    assign events = {ce_event, hi_event, vi_event};

    // Clear mask only during a port 6 write
    assign clr = int_wr ? {CD_IN[`BIT_IECE], CD_IN[`BIT_IEH], CD_IN[`BIT_IEV]} : 3'b000;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            flags <= 3'b000;
        end else begin
            flags <= (flags | events) & ~clr;   // Clear wins over same-cycle event
        end
    end

    assign int_rdata = {5'b00000, flags | events};  // Live events seen too

    // CE and VI share INT0_n
    assign INT0_n = !((flags[`BIT_IECE] && int_enable[`BIT_IECE]) ||
                      (flags[`BIT_IEV] && int_enable[`BIT_IEV]));
    assign INT1_n = !(flags[`BIT_IEH] && int_enable[`BIT_IEH]);

endmodule

// File: sim.f
+incdir+.
vdp_port_pkg.sv
cpu_port_decode.sv
vdp_register_file.sv
vram_access.sv
interrupt_flags.sv
cpu_port_top.sv
tb_vram_model.sv
tb_cpu_port.sv

// File: tb_cpu_port.sv
/*
 * Testbench of the CPU port block
 * Clock, reset, VRAM model and stimulus table
 * Table rows applied in a loop, one line per test, closing counts
 */
`timescale 1ns/1ps

module tb_cpu_port;
    import vdp_port_pkg::*;

    localparam int OP_WR   = 0;     // Port write strobe
    localparam int OP_RD   = 1;     // Port read strobe, compare CD_OUT
    localparam int OP_EV   = 2;     // Pulse {ce, hi, vi} events
    localparam int OP_PIN  = 3;     // Compare a pin group
    localparam int OP_STAT = 4;     // Set status inputs
    localparam int PIN_CD_OUT   = 0;
    localparam int PIN_WAIT_INT = 1;    // {WAIT_n, INT0_n, INT1_n}
    localparam int PIN_SYS      = 2;    // {srs, mcs}
    localparam int PIN_CMD_CNT  = 3;    // cmd_start pulses so far
    localparam int PIN_CMD_OP   = 4;    // cmd_op seen with the last pulse
    localparam int TIMEOUT = 100;

    typedef struct packed {
        int op;
        int port;
        int data;
        int exp;
        int test;
    } row_t;

    logic       CLK, RESET_n, CSR_n, CSW_n;
    port_num_t  MODE;
    cpu_data_t  CD_IN, CD_OUT, vram_din, vram_dout;
    logic       WAIT_n, INT0_n, INT1_n, vram_we_n, vram_oe_n, vram_busy, bus_error;
    vram_addr_t vram_addr;
    logic       stat_tr, stat_vr, stat_hr, stat_bd, stat_eo, stat_ce;
    logic       ce_event, hi_event, vi_event, srs, mcs, cmd_start;
    cmd_op_t    cmd_op;
    cmd_op_t    cmd_op_seen = '0;
    int         cmd_count = 0;
    row_t       rows[$];
    int         cur_test, errors, test_errors, test_checks, total_checks;
    int         tests_run, tests_failed;
    logic       aborted;

    cpu_port_top u_cpu_port_top (
        .CLK(CLK), .RESET_n(RESET_n), .CSR_n(CSR_n), .CSW_n(CSW_n), .MODE(MODE),
        .CD_IN(CD_IN), .CD_OUT(CD_OUT), .WAIT_n(WAIT_n), .INT0_n(INT0_n), .INT1_n(INT1_n),
        .vram_we_n(vram_we_n), .vram_oe_n(vram_oe_n), .vram_addr(vram_addr),
        .vram_din(vram_din), .vram_dout(vram_dout), .vram_busy(vram_busy),
        .stat_tr(stat_tr), .stat_vr(stat_vr), .stat_hr(stat_hr), .stat_bd(stat_bd),
        .stat_eo(stat_eo), .stat_ce(stat_ce), .ce_event(ce_event), .hi_event(hi_event),
        .vi_event(vi_event), .srs(srs), .mcs(mcs), .cmd_start(cmd_start), .cmd_op(cmd_op)
    );

    tb_vram_model u_vram_model (
        .CLK(CLK), .RESET_n(RESET_n), .vram_we_n(vram_we_n), .vram_oe_n(vram_oe_n),
        .vram_addr(vram_addr), .vram_din(vram_din), .vram_dout(vram_dout),
        .vram_busy(vram_busy), .bus_error(bus_error)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;          // 4 ns period
    end

    // Count command start pulses away from the rising edge
    always @(negedge CLK) begin
        if (cmd_start) begin
            cmd_count   = cmd_count + 1;
            cmd_op_seen = cmd_op;
        end
    end

    task automatic add_row(input int op, input int port, input int data, input int exp,
                           input int test);
        rows.push_back({op, port, data, exp, test});
    endtask

    task automatic report_mismatch(input string what, input cpu_data_t got,
                                   input cpu_data_t exp);
        $display("[FAIL] t=%0t test %0d: %s is %h, expected %h", $time, cur_test, what, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Test %0d went wrong at t=%0t: %s", cur_test, $time, msg);
        errors++;
        test_errors++;
    endtask

    // Two cycles low, two cycles high, entered 1 ns after an edge
    task automatic strobe(input logic is_write, input int port, input int data);
        MODE  = port_num_t'(port[3:0]);
        CD_IN = data[7:0];
        if (is_write) begin
            CSW_n = 1'b0;
        end else begin
            CSR_n = 1'b0;
        end
        @(posedge CLK);
        #1;                             // Strobe counted on that edge
        if (port == 0) begin
            test_checks++;
            if (WAIT_n !== 1'b0) begin
                report_mismatch("WAIT_n after port 0 strobe", {7'd0, WAIT_n}, 8'h00);
            end
        end
        @(posedge CLK);
        #1;
        CSR_n = 1'b1;
        CSW_n = 1'b1;
        repeat (2) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (WAIT_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (WAIT_n !== 1'b1) begin
            report_problem("timeout, WAIT_n never rose after a port 0 access");
            aborted = 1'b1;
        end
    endtask

    task automatic pulse_events(input logic [2:0] ev);
        {ce_event, hi_event, vi_event} = ev;
        @(posedge CLK);
        #1;
        {ce_event, hi_event, vi_event} = 3'b000;
        @(posedge CLK);
        #1;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %0d ok, %0d checks", cur_test, test_checks);
        end else begin
            $display("Test %0d: %0d of %0d checks wrong", cur_test, test_errors, test_checks);
            tests_failed++;
        end
        tests_run++;
        total_checks += test_checks;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic build_table();
        // 1: reset state, unserved port
        add_row(OP_PIN, 0, PIN_CD_OUT, 'hFF, 1);
        add_row(OP_PIN, 0, PIN_WAIT_INT, 'h07, 1);
        add_row(OP_RD, 3, 0, 'h00, 1);  // R#0 cleared by reset
        add_row(OP_RD, 1, 0, 'hFF, 1);
        // 2: pointer 16, three writes, read back, write inhibit on R#20
        add_row(OP_WR, 4, 'h10, 0, 2);
        add_row(OP_WR, 3, 'h11, 0, 2);
        add_row(OP_WR, 3, 'h22, 0, 2);
        add_row(OP_WR, 3, 'h33, 0, 2);
        add_row(OP_WR, 4, 'h10, 0, 2);
        add_row(OP_RD, 3, 0, 'h11, 2);
        add_row(OP_RD, 3, 0, 'h22, 2);
        add_row(OP_RD, 3, 0, 'h33, 2);
        add_row(OP_WR, 4, 'h94, 0, 2);
        add_row(OP_WR, 3, 'h55, 0, 2);
        add_row(OP_WR, 3, 'h66, 0, 2);
        add_row(OP_RD, 3, 0, 'h66, 2);
        add_row(OP_RD, 3, 0, 'h00, 2);  // R#21 never written
        // 3: write and read address 0x00100 in R#0..R#5
        add_row(OP_WR, 4, 'h00, 0, 3);
        add_row(OP_WR, 3, 'h00, 0, 3);
        add_row(OP_WR, 3, 'h01, 0, 3);
        add_row(OP_WR, 3, 'h00, 0, 3);
        add_row(OP_WR, 3, 'h00, 0, 3);
        add_row(OP_WR, 3, 'h01, 0, 3);
        add_row(OP_WR, 3, 'h00, 0, 3);
        add_row(OP_WR, 0, 'hA1, 0, 3);
        add_row(OP_WR, 0, 'hB2, 0, 3);
        add_row(OP_WR, 0, 'hC3, 0, 3);
        add_row(OP_WR, 0, 'hD4, 0, 3);
        add_row(OP_RD, 0, 0, 'hA1, 3);
        add_row(OP_RD, 0, 0, 'hB2, 3);
        add_row(OP_RD, 0, 0, 'hC3, 3);
        add_row(OP_RD, 0, 0, 'hD4, 3);
        add_row(OP_WR, 4, 'h00, 0, 3);
        add_row(OP_RD, 3, 0, 'h04, 3);  // Write address now 0x00104
        add_row(OP_RD, 3, 0, 'h01, 3);
        add_row(OP_RD, 3, 0, 'h00, 3);
        add_row(OP_WR, 4, 'h03, 0, 3);
        add_row(OP_WR, 3, 'h02, 0, 3);
        add_row(OP_WR, 3, 'h01, 0, 3);
        add_row(OP_WR, 3, 'h80, 0, 3);  // Read address 0x00102, no increment
        add_row(OP_RD, 0, 0, 'hC3, 3);
        add_row(OP_RD, 0, 0, 'hC3, 3);
        // 4: enables 7, VI on INT0_n, HI on INT1_n, clear by write
        add_row(OP_WR, 4, 'h09, 0, 4);
        add_row(OP_WR, 3, 'h07, 0, 4);
        add_row(OP_EV, 0, 'h01, 0, 4);
        add_row(OP_PIN, 0, PIN_WAIT_INT, 'h05, 4);
        add_row(OP_RD, 6, 0, 'h01, 4);
        add_row(OP_WR, 6, 'h01, 0, 4);
        add_row(OP_PIN, 0, PIN_WAIT_INT, 'h07, 4);
        add_row(OP_EV, 0, 'h02, 0, 4);
        add_row(OP_PIN, 0, PIN_WAIT_INT, 'h06, 4);
        add_row(OP_RD, 6, 0, 'h02, 4);
        add_row(OP_WR, 6, 'h02, 0, 4);
        add_row(OP_PIN, 0, PIN_WAIT_INT, 'h07, 4);
        add_row(OP_RD, 6, 0, 'h00, 4);
        // 5: system control, status, command start on R#52
        add_row(OP_WR, 7, 'h03, 0, 5);
        add_row(OP_PIN, 0, PIN_SYS, 'h03, 5);
        add_row(OP_STAT, 0, 'h80, 0, 5);
        add_row(OP_RD, 5, 0, 'h84, 5);
        add_row(OP_STAT, 0, 'h00, 0, 5);
        add_row(OP_PIN, 0, PIN_CMD_CNT, 'h00, 5);
        add_row(OP_WR, 4, 'h34, 0, 5);
        add_row(OP_WR, 3, 'hA0, 0, 5);
        add_row(OP_PIN, 0, PIN_CMD_CNT, 'h01, 5);
        add_row(OP_PIN, 0, PIN_CMD_OP, 'h0A, 5);
    endtask

    initial begin
        row_t      r;
        cpu_data_t got;
        int        i;
        RESET_n = 1'b0;
        CSR_n   = 1'b1;
        CSW_n   = 1'b1;
        MODE    = PORT_VRAM;
        CD_IN   = 8'h00;
        {stat_tr, stat_vr, stat_hr, stat_bd, stat_eo, stat_ce} = 6'b000000;
        {ce_event, hi_event, vi_event} = 3'b000;
        cur_test = 0;
        errors = 0;
        test_errors = 0;
        test_checks = 0;
        total_checks = 0;
        tests_run = 0;
        tests_failed = 0;
        aborted = 1'b0;
        build_table();
        repeat (3) @(posedge CLK);
        #1;
        RESET_n = 1'b1;
        for (i = 0; i < rows.size() && !aborted; i++) begin
            r = rows[i];
            if (r.test != cur_test) begin
                if (cur_test != 0) begin
                    finish_test();
                end
                cur_test = r.test;
            end
            case (r.op)
                OP_WR: begin
                    strobe(1'b1, r.port, r.data);
                    if (r.port == 0) begin
                        wait_ready();
                    end
                end
                OP_RD: begin
                    strobe(1'b0, r.port, 0);
                    if (r.port == 0) begin
                        wait_ready();       // CD_OUT loaded with the WAIT_n rise
                    end
                    test_checks++;
                    if (CD_OUT !== r.exp[7:0]) begin
                        report_mismatch("CD_OUT", CD_OUT, r.exp[7:0]);
                    end
                end
                OP_EV: pulse_events(r.data[2:0]);
                OP_STAT: begin
                    {stat_tr, stat_vr, stat_hr, stat_bd} = r.data[7:4];
                    {stat_eo, stat_ce} = r.data[1:0];
                    @(posedge CLK);
                    #1;
                end
                default: begin
                    case (r.data)
                        PIN_CD_OUT:   got = CD_OUT;
                        PIN_WAIT_INT: got = {5'd0, WAIT_n, INT0_n, INT1_n};
                        PIN_SYS:      got = {6'd0, srs, mcs};
                        PIN_CMD_CNT:  got = cmd_count[7:0];
                        default:      got = {4'd0, cmd_op_seen};
                    endcase
                    test_checks++;
                    if (got !== r.exp[7:0]) begin
                        report_mismatch("pin group", got, r.exp[7:0]);
                    end
                end
            endcase
        end
        if (bus_error) begin
            report_problem("the VRAM model saw a broken bus handshake");
        end
        finish_test();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb_vram_model.sv
/*
 * Behavioral VRAM for the CPU port testbench
 * 256 byte array addressed by the low address byte
 * Random busy delays around each strobe, seeded $random
 */
`timescale 1ns/1ps

module tb_vram_model (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     vram_we_n,
    input  logic                     vram_oe_n,
    input  vdp_port_pkg::vram_addr_t vram_addr,
    input  vdp_port_pkg::cpu_data_t  vram_din,
    output vdp_port_pkg::cpu_data_t  vram_dout,
    output logic                     vram_busy,
    output logic                     bus_error
);
    import vdp_port_pkg::*;

    localparam int TIMEOUT = 50;   // Cycles for the strobe to rise

    cpu_data_t mem [256];
    integer    seed;
    int        ack_dly;                 // 0..3 cycles to busy rise
    int        done_dly;                // 1..4 cycles to busy fall
    int        n;
    logic      is_rd;

    initial begin
        seed      = 55114;
        vram_dout = 8'h00;
        vram_busy = 1'b0;
        bus_error = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i[7:0];                // Fill with own index
        end
        forever begin
            @(posedge CLK);
            #1;
            if (RESET_n && (!vram_we_n || !vram_oe_n)) begin
                is_rd = !vram_oe_n;
                if (!vram_we_n) begin
                    mem[vram_addr[7:0]] = vram_din;  // Address and data stable now
                end
                ack_dly  = $random(seed) & 3;
                done_dly = ($random(seed) & 3) + 1;
                repeat (ack_dly) begin
                    @(posedge CLK);
                    #1;
                end
                vram_busy = 1'b1;                   // Acknowledge
                n = 0;
                while ((!vram_we_n || !vram_oe_n) && n < TIMEOUT) begin
                    @(posedge CLK);
                    #1;
                    n++;
                end
                if (!vram_we_n || !vram_oe_n) begin
                    $display("VRAM model: strobe still low after acknowledge at t=%0t", $time);
                    bus_error = 1'b1;
                end
                repeat (done_dly) begin
                    @(posedge CLK);
                    #1;
                end
                if (is_rd) begin
                    vram_dout = mem[vram_addr[7:0]];
                end
                vram_busy = 1'b0;                   // Completion, read data valid
            end
        end
    end

endmodule

// File: vdp_port_defines.svh
/*
 * Register indices of the VDP register file
 * Field bit positions used by the CPU port block
 * Idle value of the CPU data bus
 */
`ifndef VDP_PORT_DEFINES_SVH
`define VDP_PORT_DEFINES_SVH

`define VDP_NUM_REGS    64          // R#0 .. R#63

// VRAM write and read address registers
`define REG_CVWA0       6'd0        // Write address 7:0
`define REG_CVWA1       6'd1        // Write address 15:8
`define REG_CVWA2       6'd2        // Write address 18:16, inhibit
`define REG_CVRA0       6'd3        // Read address 7:0
`define REG_CVRA1       6'd4
`define REG_CVRA2       6'd5
`define REG_INT_EN      6'd9        // Interrupt enables
`define REG_CMD         6'd52       // Opcode in 7:4, write starts command

`define BIT_ADDR_IH     7           // Address increment inhibit, R#2 / R#5
`define BIT_IECE        2           // Enables in R#9, same order as flags
`define BIT_IEH         1
`define BIT_IEV         0
`define BIT_PTR_WINH    7           // Port 4 pointer, no inc on write
`define BIT_PTR_RINH    6           // No inc on read

`define CD_IDLE         8'hFF       // Unserved reads and reset value

`endif

// File: vdp_port_pkg.sv
/*
 * Shared types of the CPU port block
 * Data, address, register index and pointer vectors
 * MODE port numbers and VRAM access FSM states
 */
package vdp_port_pkg;

    typedef logic [7:0]  cpu_data_t;   // CPU bus byte or one register
    typedef logic [18:0] vram_addr_t;  // VRAM byte address
    typedef logic [5:0]  reg_num_t;    // Register index
    typedef logic [7:0]  reg_ptr_t;    // WINH, RINH, index 5:0
    typedef logic [3:0]  cmd_op_t;     // Command opcode

    // MODE pin encoding
    typedef enum logic [3:0] {
        PORT_VRAM     = 4'd0,
        PORT_PALETTE  = 4'd1,          // Not served here
        PORT_CMD_DATA = 4'd2,          // Not served here
        PORT_REG_DATA = 4'd3,
        PORT_REG_SEL  = 4'd4,
        PORT_STATUS   = 4'd5,
        PORT_INT_FLAG = 4'd6,
        PORT_SYS_CTRL = 4'd7
    } port_num_t;

    typedef enum logic [2:0] {
        VRAM_IDLE,
        VRAM_WR_ACK,                   // WE_n low, wait busy rise
        VRAM_WR_DONE,                  // Wait busy fall
        VRAM_RD_ACK,                   // OE_n low, wait busy rise
        VRAM_RD_DONE                   // Wait busy fall, take data
    } vram_state_t;

endpackage

// File: vdp_register_file.sv
/*
 * 64 x 8 VDP register file behind ports 3 and 4
 * Port 4 pointer with read and write inhibit bits
 * VRAM write / read address increment on port 0 access
 * Interrupt enables, command start pulse and opcode
 */
`timescale 1ns/1ps
`include "vdp_port_defines.svh"

module vdp_register_file (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     reg_wr,
    input  logic                     reg_rd,
    input  logic                     ptr_wr,
    input  logic                     vram_wr,
    input  logic                     vram_rd,
    input  vdp_port_pkg::cpu_data_t  CD_IN,
    output vdp_port_pkg::cpu_data_t  reg_rdata,
    output vdp_port_pkg::vram_addr_t vram_waddr,
    output vdp_port_pkg::vram_addr_t vram_raddr,
    output logic [2:0]               int_enable,
    output logic                     cmd_start,
    output vdp_port_pkg::cmd_op_t    cmd_op
);
    import vdp_port_pkg::*;

    cpu_data_t  regs [`VDP_NUM_REGS];
    reg_ptr_t   ptr;            // Port 4 value
    reg_num_t   reg_idx;
    reg_num_t   reg_idx_next;
    vram_addr_t waddr_inc;
    vram_addr_t raddr_inc;
    logic       waddr_ih;       // Increment inhibits
    logic       raddr_ih;

    assign reg_idx      = ptr[5:0];
    assign reg_idx_next = reg_idx + 6'd1;   // Wraps 63 -> 0

    // 19 bit addresses spread over three registers each
    assign vram_waddr = {regs[`REG_CVWA2][2:0], regs[`REG_CVWA1], regs[`REG_CVWA0]};
    assign vram_raddr = {regs[`REG_CVRA2][2:0], regs[`REG_CVRA1], regs[`REG_CVRA0]};
    assign waddr_inc  = vram_waddr + 19'd1;
    assign raddr_inc  = vram_raddr + 19'd1;
    assign waddr_ih   = regs[`REG_CVWA2][`BIT_ADDR_IH];
    assign raddr_ih   = regs[`REG_CVRA2][`BIT_ADDR_IH];

    assign reg_rdata = regs[reg_idx];   // Sampled by top on the read edge

    // Enable order matches the flag bits
    assign int_enable = {regs[`REG_INT_EN][`BIT_IECE],
                         regs[`REG_INT_EN][`BIT_IEH],
                         regs[`REG_INT_EN][`BIT_IEV]};

    assign cmd_op = regs[`REG_CMD][7:4];

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < `VDP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr) begin
            regs[reg_idx] <= CD_IN;             // Port 3 write
        end else if (vram_wr && !waddr_ih) begin
            // Bump at access start, VRAM side got the old address
            regs[`REG_CVWA0]      <= waddr_inc[7:0];
            regs[`REG_CVWA1]      <= waddr_inc[15:8];
            regs[`REG_CVWA2][2:0] <= waddr_inc[18:16];
        end else if (vram_rd && !raddr_ih) begin
            regs[`REG_CVRA0]      <= raddr_inc[7:0];
            regs[`REG_CVRA1]      <= raddr_inc[15:8];
            regs[`REG_CVRA2][2:0] <= raddr_inc[18:16];
        end
    end

    // Pointer, inhibit bits kept across increments
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            ptr <= '0;
        end else if (ptr_wr) begin
            ptr <= CD_IN;
        end else if (reg_wr && !ptr[`BIT_PTR_WINH]) begin
            ptr <= {ptr[7:6], reg_idx_next};
        end else if (reg_rd && !ptr[`BIT_PTR_RINH]) begin
            ptr <= {ptr[7:6], reg_idx_next};
        end
    end

    // One cycle after the write to R#52
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= reg_wr && (reg_idx == `REG_CMD);
        end
    end

endmodule

// File: vram_access.sv
/*
 * One CPU byte access on the VRAM bus
 * Strobe, busy rise as acknowledge, busy fall as completion
 * Done pulse with the read byte
 */
`timescale 1ns/1ps

module vram_access (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     vram_wr,
    input  logic                     vram_rd,
    input  vdp_port_pkg::vram_addr_t vram_waddr,
    input  vdp_port_pkg::vram_addr_t vram_raddr,
    input  vdp_port_pkg::cpu_data_t  CD_IN,
    output logic                     vram_we_n,
    output logic                     vram_oe_n,
    output vdp_port_pkg::vram_addr_t vram_addr,
    output vdp_port_pkg::cpu_data_t  vram_din,
    input  vdp_port_pkg::cpu_data_t  vram_dout,
    input  logic                     vram_busy,
    output logic                     vram_done,
    output vdp_port_pkg::cpu_data_t  vram_rdata
);
    import vdp_port_pkg::*;

    vram_state_t state;

    // Control side of the handshake
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state     <= VRAM_IDLE;
            vram_we_n <= 1'b1;
            vram_oe_n <= 1'b1;
            vram_done <= 1'b0;
        end else begin
            vram_done <= 1'b0;                      // Pulse only
            case (state)
                VRAM_IDLE: begin
                    if (vram_wr) begin
                        vram_we_n <= 1'b0;
                        state     <= VRAM_WR_ACK;
                    end else if (vram_rd) begin
                        vram_oe_n <= 1'b0;
                        state     <= VRAM_RD_ACK;
                    end
                end
                VRAM_WR_ACK: if (vram_busy) begin   // Acknowledged
                    vram_we_n <= 1'b1;
                    state     <= VRAM_WR_DONE;
                end
                VRAM_WR_DONE: if (!vram_busy) begin
                    vram_done <= 1'b1;
                    state     <= VRAM_IDLE;
                end
                VRAM_RD_ACK: if (vram_busy) begin
                    vram_oe_n <= 1'b1;
                    state     <= VRAM_RD_DONE;
                end
                VRAM_RD_DONE: if (!vram_busy) begin // Data valid now
                    vram_done <= 1'b1;
                    state     <= VRAM_IDLE;
                end
                default: state <= VRAM_IDLE;
            endcase
        end
    end

    // Address, write data and read data
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            vram_addr  <= '0;
            vram_din   <= '0;
            vram_rdata <= '0;
        end else begin
            if (state == VRAM_IDLE && vram_wr) begin
                vram_addr <= vram_waddr;            // Held for whole access
                vram_din  <= CD_IN;
            end else if (state == VRAM_IDLE && vram_rd) begin
                vram_addr <= vram_raddr;
            end
            if (state == VRAM_RD_DONE && !vram_busy) begin
                vram_rdata <= vram_dout;
            end
        end
    end

endmodule
